//--- src/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

	localparam int lc3b_word_w = 16; // data and address width.
	localparam int lc3b_reg_cnt = 8;
	localparam int lc3b_idx_w = $clog2(lc3b_reg_cnt); // register index width.

	// isa opcode field, bits 15:12.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_pass,
		alu_add,
		alu_and,
		alu_not,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op;

	// second alu operand.
	typedef enum logic [1:0] {
		src_reg,
		src_imm5, // sign extended.
		src_imm4  // zero extended shift amount.
	} operand_src;

	typedef enum logic [1:0] {
		rf_alu,
		rf_link, // pc + 2.
		rf_lea
	} regfile_src;

	// redirect target.
	typedef enum logic [1:0] {
		tgt_none,
		tgt_branch, // conditional on nzp.
		tgt_off11,
		tgt_base
	} target_src;

endpackage

`default_nettype wire

//--- src/control_rom.sv
`timescale 1ns/1ns
`default_nettype none

module control_rom (
	input  lc3b_pkg::lc3b_opcode opcode,
	input  logic                 ir4,
	input  logic                 ir5,
	input  logic                 ir11,
	output logic                 load_regfile,
	output logic                 load_cc,
	output logic                 dest_link,
	output lc3b_pkg::alu_op      aluop,
	output lc3b_pkg::operand_src operand_sel,
	output lc3b_pkg::regfile_src regfile_sel,
	output lc3b_pkg::target_src  target_sel
);

	import lc3b_pkg::*;

	always_comb begin
		// everything inactive unless the opcode says otherwise.
		load_regfile = 1'b0;
		load_cc = 1'b0;
		dest_link = 1'b0;
		aluop = alu_pass;
		operand_sel = src_reg;
		regfile_sel = rf_alu;
		target_sel = tgt_none;

		case (opcode)
			op_add: begin
				if (ir5)
					operand_sel = src_imm5; // dr = sr1 + sext(imm5).
				aluop = alu_add;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end

			op_and: begin
				if (ir5)
					operand_sel = src_imm5;
				aluop = alu_and;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end

			op_not: begin
				aluop = alu_not; // dr = ~sr1.
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end

			op_shf: begin
				operand_sel = src_imm4;
				if (!ir4)
					aluop = alu_sll;
				else if (!ir5)
					aluop = alu_srl;
				else
					aluop = alu_sra;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end

			op_lea: begin
				// dr = pc + 2 + (sext(offset9) << 1).
				regfile_sel = rf_lea;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end

			op_br: begin
				target_sel = tgt_branch; // taken only on nzp match.
			end

			op_jmp: begin
				target_sel = tgt_base;
			end

			op_jsr: begin
				// r7 gets the return address.
				dest_link = 1'b1;
				regfile_sel = rf_link;
				load_regfile = 1'b1;
				if (ir11)
					target_sel = tgt_off11; // jsr.
				else
					target_sel = tgt_base; // jsrr.
			end

			// loads, stores, rti and trap retire as bubbles.
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                instr_valid,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]    instr,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]    instr_pc,
	output logic [lc3b_pkg::lc3b_idx_w-1:0]     sr1_idx,
	output logic [lc3b_pkg::lc3b_idx_w-1:0]     sr2_idx,
	output logic [lc3b_pkg::lc3b_idx_w-1:0]     dest_idx,
	output logic                                dec_valid,
	output logic [lc3b_pkg::lc3b_word_w-1:0]    dec_pc,
	output logic [4:0]                          imm5,
	output logic [3:0]                          imm4,
	output logic [8:0]                          offset9,
	output logic [10:0]                         offset11,
	output logic [2:0]                          nzp_mask,
	output logic                                load_regfile,
	output logic                                load_cc,
	output lc3b_pkg::alu_op                     aluop,
	output lc3b_pkg::operand_src                operand_sel,
	output lc3b_pkg::regfile_src                regfile_sel,
	output lc3b_pkg::target_src                 target_sel
);

	import lc3b_pkg::*;

	logic [lc3b_word_w-1:0] ir;
	lc3b_opcode opcode;
	logic dest_link;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= instr_valid;
	end

	always_ff @(posedge clk) begin
		ir <= instr;
		dec_pc <= instr_pc;
	end

	assign opcode = lc3b_opcode'(ir[15:12]);

	// field slices, immediates go out raw.
	assign sr1_idx = ir[8:6];
	assign sr2_idx = ir[2:0];
	assign imm5 = ir[4:0];
	assign imm4 = ir[3:0];
	assign offset9 = ir[8:0];
	assign offset11 = ir[10:0];
	assign nzp_mask = ir[11:9];
	assign dest_idx = dest_link ? lc3b_idx_w'(7) : ir[11:9]; // link goes to r7.

	control_rom u_control_rom (
		.opcode       (opcode),
		.ir4          (ir[4]),
		.ir5          (ir[5]),
		.ir11         (ir[11]),
		.load_regfile (load_regfile),
		.load_cc      (load_cc),
		.dest_link    (dest_link),
		.aluop        (aluop),
		.operand_sel  (operand_sel),
		.regfile_sel  (regfile_sel),
		.target_sel   (target_sel)
	);

endmodule

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             wr_en,
	input  logic [lc3b_pkg::lc3b_idx_w-1:0]  wr_idx,
	input  logic [lc3b_pkg::lc3b_word_w-1:0] wr_data,
	input  logic [lc3b_pkg::lc3b_idx_w-1:0]  rd_a_idx,
	input  logic [lc3b_pkg::lc3b_idx_w-1:0]  rd_b_idx,
	output logic [lc3b_pkg::lc3b_word_w-1:0] rd_a_data,
	output logic [lc3b_pkg::lc3b_word_w-1:0] rd_b_data
);

	import lc3b_pkg::*;

	logic [lc3b_word_w-1:0] regs [lc3b_reg_cnt];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < lc3b_reg_cnt; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// a pending write shows up on the read ports in the same cycle.
	assign rd_a_data = (wr_en && wr_idx == rd_a_idx) ? wr_data : regs[rd_a_idx];
	assign rd_b_data = (wr_en && wr_idx == rd_b_idx) ? wr_data : regs[rd_b_idx];

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  lc3b_pkg::alu_op                  aluop,
	input  logic [lc3b_pkg::lc3b_word_w-1:0] a,
	input  logic [lc3b_pkg::lc3b_word_w-1:0] b,
	output logic [lc3b_pkg::lc3b_word_w-1:0] f
);

	import lc3b_pkg::*;

	logic [3:0] shamt;

	assign shamt = b[3:0]; // shifts only look at imm4.

	always_comb begin
		case (aluop)
			alu_add:  f = a + b;
			alu_and:  f = a & b;
			alu_not:  f = ~a;
			alu_sll:  f = a << shamt;
			alu_srl:  f = a >> shamt;
			alu_sra:  f = $unsigned($signed(a) >>> shamt); // keeps the sign bit.
			default:  f = a; // pass.
		endcase
	end

endmodule

`default_nettype wire

//--- src/exec_stage.sv
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             dec_valid,
	input  logic [lc3b_pkg::lc3b_word_w-1:0] dec_pc,
	input  logic [lc3b_pkg::lc3b_idx_w-1:0]  sr1_idx,
	input  logic [lc3b_pkg::lc3b_idx_w-1:0]  sr2_idx,
	input  logic [lc3b_pkg::lc3b_idx_w-1:0]  dest_idx,
	input  logic [4:0]                       imm5,
	input  logic [3:0]                       imm4,
	input  logic [8:0]                       offset9,
	input  logic [10:0]                      offset11,
	input  logic [2:0]                       nzp_mask,
	input  logic                             load_regfile,
	input  logic                             load_cc,
	input  lc3b_pkg::alu_op                  aluop,
	input  lc3b_pkg::operand_src             operand_sel,
	input  lc3b_pkg::regfile_src             regfile_sel,
	input  lc3b_pkg::target_src              target_sel,
	input  logic [lc3b_pkg::lc3b_word_w-1:0] sr1_data,
	input  logic [lc3b_pkg::lc3b_word_w-1:0] sr2_data,
	output logic                             wr_en,
	output logic [lc3b_pkg::lc3b_idx_w-1:0]  wr_idx,
	output logic [lc3b_pkg::lc3b_word_w-1:0] wr_data,
	output logic [2:0]                       cc,
	output logic                             redirect,
	output logic [lc3b_pkg::lc3b_word_w-1:0] redirect_pc
);

	import lc3b_pkg::*;

	logic ex_valid, ex_load_regfile, ex_load_cc;
	logic [lc3b_word_w-1:0] ex_pc, ex_a, ex_b;
	logic [lc3b_idx_w-1:0] ex_dest;
	logic [4:0] ex_imm5;
	logic [3:0] ex_imm4;
	logic [8:0] ex_off9;
	logic [10:0] ex_off11;
	logic [2:0] ex_nzp;
	alu_op ex_aluop;
	operand_src ex_operand_sel;
	regfile_src ex_regfile_sel;
	target_src ex_target_sel;

	logic [lc3b_word_w-1:0] alu_b, alu_f, pc_plus2, off9_tgt, off11_tgt;
	logic [lc3b_word_w-1:0] result, target;
	logic [2:0] res_nzp;
	logic res_wr, take_redirect;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec_valid;
	end

	// operand capture, forwarding the result this stage is retiring.
	always_ff @(posedge clk) begin
		ex_a <= (res_wr && ex_dest == sr1_idx) ? result : sr1_data;
		ex_b <= (res_wr && ex_dest == sr2_idx) ? result : sr2_data;
		ex_pc <= dec_pc;
		ex_dest <= dest_idx;
		ex_imm5 <= imm5;
		ex_imm4 <= imm4;
		ex_off9 <= offset9;
		ex_off11 <= offset11;
		ex_nzp <= nzp_mask;
		ex_load_regfile <= load_regfile;
		ex_load_cc <= load_cc;
		ex_aluop <= aluop;
		ex_operand_sel <= operand_sel;
		ex_regfile_sel <= regfile_sel;
		ex_target_sel <= target_sel;
	end

	always_comb begin
		case (ex_operand_sel)
			src_imm5: alu_b = {{(lc3b_word_w-5){ex_imm5[4]}}, ex_imm5};
			src_imm4: alu_b = {{(lc3b_word_w-4){1'b0}}, ex_imm4};
			default:  alu_b = ex_b;
		endcase
	end

	alu u_alu (
		.aluop (ex_aluop),
		.a     (ex_a),
		.b     (alu_b),
		.f     (alu_f)
	);

	// pc relative targets, offsets are word counts.
	assign pc_plus2 = ex_pc + lc3b_word_w'(2);
	assign off9_tgt = pc_plus2 + {{(lc3b_word_w-10){ex_off9[8]}}, ex_off9, 1'b0};
	assign off11_tgt = pc_plus2 + {{(lc3b_word_w-12){ex_off11[10]}}, ex_off11, 1'b0};

	always_comb begin
		case (ex_regfile_sel)
			rf_link: result = pc_plus2;
			rf_lea:  result = off9_tgt;
			default: result = alu_f;
		endcase
	end

	assign res_wr = ex_valid && ex_load_regfile;
	assign res_nzp = {result[lc3b_word_w-1], result == '0,
		!result[lc3b_word_w-1] && result != '0};

	always_comb begin
		case (ex_target_sel)
			tgt_branch: target = off9_tgt;
			tgt_off11:  target = off11_tgt;
			default:    target = ex_a; // base register.
		endcase
	end

	// branch tests cc before any update from this instruction.
	assign take_redirect = ex_valid && (ex_target_sel == tgt_branch ? |(ex_nzp & cc) :
		ex_target_sel != tgt_none);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_en <= 1'b0;
			redirect <= 1'b0;
			cc <= 3'b010; // z after reset.
		end else begin
			wr_en <= res_wr;
			redirect <= take_redirect;
			if (ex_valid && ex_load_cc)
				cc <= res_nzp;
		end
	end

	always_ff @(posedge clk) begin
		wr_idx <= ex_dest;
		wr_data <= result;
		redirect_pc <= target;
	end

endmodule

`default_nettype wire

//--- src/lc3b_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_datapath (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             instr_valid,
	input  logic [lc3b_pkg::lc3b_word_w-1:0] instr,
	input  logic [lc3b_pkg::lc3b_word_w-1:0] instr_pc,
	output logic                             wb_valid,
	output logic [lc3b_pkg::lc3b_idx_w-1:0]  wb_idx,
	output logic [lc3b_pkg::lc3b_word_w-1:0] wb_data,
	output logic [2:0]                       cc,
	output logic                             redirect,
	output logic [lc3b_pkg::lc3b_word_w-1:0] redirect_pc
);

	import lc3b_pkg::*;

	logic [lc3b_idx_w-1:0] sr1_idx, sr2_idx, dest_idx;
	logic dec_valid, load_regfile, load_cc;
	logic [lc3b_word_w-1:0] dec_pc, sr1_data, sr2_data;
	logic [4:0] imm5;
	logic [3:0] imm4;
	logic [8:0] offset9;
	logic [10:0] offset11;
	logic [2:0] nzp_mask;
	alu_op aluop;
	operand_src operand_sel;
	regfile_src regfile_sel;
	target_src target_sel;

	decode_stage u_decode (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.instr_pc     (instr_pc),
		.sr1_idx      (sr1_idx),
		.sr2_idx      (sr2_idx),
		.dest_idx     (dest_idx),
		.dec_valid    (dec_valid),
		.dec_pc       (dec_pc),
		.imm5         (imm5),
		.imm4         (imm4),
		.offset9      (offset9),
		.offset11     (offset11),
		.nzp_mask     (nzp_mask),
		.load_regfile (load_regfile),
		.load_cc      (load_cc),
		.aluop        (aluop),
		.operand_sel  (operand_sel),
		.regfile_sel  (regfile_sel),
		.target_sel   (target_sel)
	);

	// write port is driven straight from the execute stage outputs.
	regfile u_regfile (
		.clk       (clk),
		.arst_n    (arst_n),
		.wr_en     (wb_valid),
		.wr_idx    (wb_idx),
		.wr_data   (wb_data),
		.rd_a_idx  (sr1_idx),
		.rd_b_idx  (sr2_idx),
		.rd_a_data (sr1_data),
		.rd_b_data (sr2_data)
	);

	exec_stage u_exec (
		.clk          (clk),
		.arst_n       (arst_n),
		.dec_valid    (dec_valid),
		.dec_pc       (dec_pc),
		.sr1_idx      (sr1_idx),
		.sr2_idx      (sr2_idx),
		.dest_idx     (dest_idx),
		.imm5         (imm5),
		.imm4         (imm4),
		.offset9      (offset9),
		.offset11     (offset11),
		.nzp_mask     (nzp_mask),
		.load_regfile (load_regfile),
		.load_cc      (load_cc),
		.aluop        (aluop),
		.operand_sel  (operand_sel),
		.regfile_sel  (regfile_sel),
		.target_sel   (target_sel),
		.sr1_data     (sr1_data),
		.sr2_data     (sr2_data),
		.wr_en        (wb_valid),
		.wr_idx       (wb_idx),
		.wr_data      (wb_data),
		.cc           (cc),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc)
	);

endmodule

`default_nettype wire

//--- test/lc3b_tb_model.svh
`ifndef LC3B_TB_MODEL_SVH
`define LC3B_TB_MODEL_SVH

// instruction encoders, fields in isa order.
function automatic logic [15:0] enc_alu_reg(lc3b_opcode op, logic [2:0] dr, logic [2:0] sr1,
	logic [2:0] sr2);
	return {op, dr, sr1, 3'b000, sr2};
endfunction

function automatic logic [15:0] enc_alu_imm(lc3b_opcode op, logic [2:0] dr, logic [2:0] sr1,
	logic [4:0] imm);
	return {op, dr, sr1, 1'b1, imm};
endfunction

function automatic logic [15:0] enc_not(logic [2:0] dr, logic [2:0] sr);
	return {op_not, dr, sr, 6'h3f};
endfunction

// kind is {ir5, ir4}.
function automatic logic [15:0] enc_shf(logic [2:0] dr, logic [2:0] sr, logic [1:0] kind,
	logic [3:0] amt);
	return {op_shf, dr, sr, kind, amt};
endfunction

function automatic logic [15:0] enc_lea(logic [2:0] dr, logic [8:0] off9);
	return {op_lea, dr, off9};
endfunction

function automatic logic [15:0] enc_br(logic [2:0] nzp, logic [8:0] off9);
	return {op_br, nzp, off9};
endfunction

function automatic logic [15:0] enc_jmp(logic [2:0] base);
	return {op_jmp, 3'b000, base, 6'b000000};
endfunction

function automatic logic [15:0] enc_jsr(logic [10:0] off11);
	return {op_jsr, 1'b1, off11};
endfunction

function automatic logic [15:0] enc_jsrr(logic [2:0] base);
	return {op_jsr, 1'b0, 2'b00, base, 6'b000000};
endfunction

// sign extends the low bits of raw.
function automatic logic [15:0] sext_field(logic [15:0] raw, int bits);
	logic [15:0] r;
	r = raw;
	for (int i = bits; i < 16; i++)
		r[i] = raw[bits-1];
	return r;
endfunction

// pc relative target, offset counts words.
function automatic logic [15:0] pc_rel(logic [15:0] pc, logic [15:0] raw, int bits);
	return pc + 16'd2 + (sext_field(raw, bits) << 1);
endfunction

function automatic logic [2:0] nzp_of(logic [15:0] v);
	if (v == 16'h0000)
		return 3'b010;
	else if (v[15])
		return 3'b100;
	else
		return 3'b001;
endfunction

function automatic logic [15:0] shift_model(logic [15:0] a, logic [1:0] kind, logic [3:0] amt);
	logic [15:0] r;
	r = a;
	if (!kind[0]) begin
		r = a << amt; // lshf.
	end else begin
		for (int i = 0; i < amt; i++)
			r = {kind[1] & r[15], r[15:1]}; // fill with sign only for rshfa.
	end
	return r;
endfunction

`endif

//--- test/tb_lc3b_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lc3b_datapath;

	import lc3b_pkg::*;

	`include "lc3b_tb_model.svh"

	localparam int n_arith = 48;
	localparam int n_shift = 24;
	localparam int n_chain = 12;
	localparam int n_ctl = 6;
	localparam int n_mem = 8;
	localparam int instr_budget = 6 + 2 * lc3b_reg_cnt + n_arith + 2 * n_shift + 3 * n_chain +
		4 + 4 * n_ctl + 27 + 2 * n_mem + 3;
	localparam int timeout_ns = (instr_budget + 4 + 20) * 10; // reset plus some slack.

	logic clk;
	logic arst_n;
	logic instr_valid;
	logic [lc3b_word_w-1:0] instr;
	logic [lc3b_word_w-1:0] instr_pc;
	logic wb_valid;
	logic [lc3b_idx_w-1:0] wb_idx;
	logic [lc3b_word_w-1:0] wb_data;
	logic [2:0] cc;
	logic redirect;
	logic [lc3b_word_w-1:0] redirect_pc;

	int errors;
	logic [31:0] lcg_state;

	// architectural state after every issued instruction.
	logic [15:0] shadow_reg [8];
	logic [2:0] shadow_cc;

	// expected outputs, index 2 is due at the current falling edge.
	logic p_wb [3];
	logic [2:0] p_idx [3];
	logic [15:0] p_data [3];
	logic p_redir [3];
	logic [15:0] p_rpc [3];
	logic [2:0] p_cc [3];
	logic [15:0] p_pc [3];

	lc3b_datapath UUT (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.wb_valid    (wb_valid),
		.wb_idx      (wb_idx),
		.wb_data     (wb_data),
		.cc          (cc),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(timeout_ns);
		$display("timeout: the run did not finish within %0d ns", timeout_ns);
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic logic [15:0] rand_pc();
		logic [15:0] t;
		t = rand16();
		return {t[15:1], 1'b0}; // word aligned.
	endfunction

	// isa rules applied in program order.
	task automatic predict(input logic valid, input logic [15:0] word, input logic [15:0] pc,
		output logic wb, output logic [2:0] idx, output logic [15:0] data,
		output logic redir, output logic [15:0] rpc);
		logic [15:0] a;
		logic [15:0] b;
		logic sets_cc;
		wb = 1'b0;
		redir = 1'b0;
		sets_cc = 1'b0;
		idx = word[11:9];
		data = 16'h0000;
		rpc = 16'h0000;
		a = shadow_reg[word[8:6]];
		b = word[5] ? sext_field(word, 5) : shadow_reg[word[2:0]];
		if (valid) begin
			case (word[15:12])
				op_add: begin
					wb = 1'b1;
					sets_cc = 1'b1;
					data = a + b;
				end
				op_and: begin
					wb = 1'b1;
					sets_cc = 1'b1;
					data = a & b;
				end
				op_not: begin
					wb = 1'b1;
					sets_cc = 1'b1;
					data = ~a;
				end
				op_shf: begin
					wb = 1'b1;
					sets_cc = 1'b1;
					data = shift_model(a, word[5:4], word[3:0]);
				end
				op_lea: begin
					wb = 1'b1;
					sets_cc = 1'b1;
					data = pc_rel(pc, word, 9);
				end
				op_br: begin
					redir = |(word[11:9] & shadow_cc); // cc before this instruction.
					rpc = pc_rel(pc, word, 9);
				end
				op_jmp: begin
					redir = 1'b1;
					rpc = a;
				end
				op_jsr: begin
					wb = 1'b1;
					idx = 3'd7;
					data = pc + 16'd2;
					redir = 1'b1;
					rpc = word[11] ? pc_rel(pc, word, 11) : a; // base read before the link.
				end
				default: begin
				end
			endcase
		end
		if (wb)
			shadow_reg[idx] = data;
		if (sets_cc)
			shadow_cc = nzp_of(data);
	endtask

	task automatic check_outputs();
		if (wb_valid !== p_wb[2]) begin
			$display("MISMATCH wb_valid: expected %h, got %h (pc %h)", p_wb[2], wb_valid, p_pc[2]);
			errors++;
		end
		if (p_wb[2] && wb_idx !== p_idx[2]) begin
			$display("MISMATCH wb_idx: expected %h, got %h (pc %h)", p_idx[2], wb_idx, p_pc[2]);
			errors++;
		end
		if (p_wb[2] && wb_data !== p_data[2]) begin
			$display("MISMATCH wb_data: expected %h, got %h (pc %h)", p_data[2], wb_data, p_pc[2]);
			errors++;
		end
		if (redirect !== p_redir[2]) begin
			$display("MISMATCH redirect: expected %h, got %h (pc %h)", p_redir[2], redirect,
				p_pc[2]);
			errors++;
		end
		if (p_redir[2] && redirect_pc !== p_rpc[2]) begin
			$display("MISMATCH redirect_pc: expected %h, got %h (pc %h)", p_rpc[2], redirect_pc,
				p_pc[2]);
			errors++;
		end
		if (cc !== p_cc[2]) begin
			$display("MISMATCH cc: expected %h, got %h (pc %h)", p_cc[2], cc, p_pc[2]);
			errors++;
		end
	endtask

	// one cycle: check what is due, then drive the next slot.
	task automatic issue(input logic valid, input logic [15:0] word, input logic [15:0] pc);
		logic wb;
		logic redir;
		logic [2:0] idx;
		logic [15:0] data;
		logic [15:0] rpc;
		@(negedge clk);
		check_outputs();
		for (int i = 2; i > 0; i--) begin
			p_wb[i] = p_wb[i-1];
			p_idx[i] = p_idx[i-1];
			p_data[i] = p_data[i-1];
			p_redir[i] = p_redir[i-1];
			p_rpc[i] = p_rpc[i-1];
			p_cc[i] = p_cc[i-1];
			p_pc[i] = p_pc[i-1];
		end
		predict(valid, word, pc, wb, idx, data, redir, rpc);
		p_wb[0] = wb;
		p_idx[0] = idx;
		p_data[0] = data;
		p_redir[0] = redir;
		p_rpc[0] = rpc;
		p_cc[0] = shadow_cc;
		p_pc[0] = pc;
		instr_valid = valid;
		instr = word;
		instr_pc = pc;
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++)
			issue(1'b0, rand16(), rand16()); // junk bits must be ignored.
	endtask

	task automatic reset_test();
		@(negedge clk);
		if (wb_valid !== 1'b0) begin
			$display("MISMATCH wb_valid after reset: expected 0, got %h", wb_valid);
			errors++;
		end
		if (redirect !== 1'b0) begin
			$display("MISMATCH redirect after reset: expected 0, got %h", redirect);
			errors++;
		end
		if (cc !== 3'b010) begin
			$display("MISMATCH cc after reset: expected 2, got %h", cc);
			errors++;
		end
		issue(1'b1, enc_alu_imm(op_add, 3'd1, 3'd0, 5'd0), 16'h3000);
		idle(3);
	endtask

	task automatic seed_test();
		logic [15:0] r;
		for (int i = 0; i < lc3b_reg_cnt; i++) begin
			r = rand16();
			issue(1'b1, enc_alu_imm(op_and, 3'(i), 3'(i), 5'd0), rand_pc());
			issue(1'b1, enc_alu_imm(op_add, 3'(i), 3'(i), r[4:0]), rand_pc());
		end
	endtask

	task automatic arith_test();
		logic [15:0] r;
		logic [15:0] word;
		for (int i = 0; i < n_arith; i++) begin
			r = rand16();
			case (i % 5)
				0: word = enc_alu_reg(op_add, r[2:0], r[5:3], r[8:6]);
				1: word = enc_alu_imm(op_add, r[2:0], r[5:3], r[13:9]);
				2: word = enc_alu_reg(op_and, r[2:0], r[5:3], r[8:6]);
				3: word = enc_alu_imm(op_and, r[2:0], r[5:3], r[13:9]);
				default: word = enc_not(r[2:0], r[5:3]);
			endcase
			issue(1'b1, word, rand_pc());
		end
	endtask

	task automatic shift_test();
		logic [15:0] r;
		logic [1:0] kind;
		for (int i = 0; i < n_shift; i++) begin
			r = rand16();
			kind = (i % 3 == 0) ? 2'b00 : (i % 3 == 1) ? 2'b01 : 2'b11;
			// make sure rshfa sees a negative source.
			if (kind == 2'b11 && !shadow_reg[r[5:3]][15])
				issue(1'b1, enc_not(r[5:3], r[5:3]), rand_pc());
			issue(1'b1, enc_shf(r[2:0], r[5:3], kind, r[9:6]), rand_pc());
		end
	endtask

	task automatic chain_step(input int i);
		logic [15:0] r;
		r = rand16();
		case (i % 3)
			0: issue(1'b1, enc_alu_imm(op_add, 3'd3, 3'd3, r[4:0]), rand_pc());
			1: issue(1'b1, enc_alu_reg(op_add, 3'd3, 3'd3, 3'd3), rand_pc());
			default: issue(1'b1, enc_not(3'd3, 3'd3), rand_pc());
		endcase
	endtask

	task automatic bypass_test();
		for (int i = 0; i < n_chain; i++)
			chain_step(i);
		for (int i = 0; i < n_chain; i++) begin
			chain_step(i);
			idle(1);
		end
		// one source from the previous instruction, one from two back.
		issue(1'b1, enc_alu_imm(op_add, 3'd4, 3'd4, 5'd5), rand_pc());
		issue(1'b1, enc_alu_imm(op_add, 3'd5, 3'd5, 5'h1e), rand_pc());
		issue(1'b1, enc_alu_reg(op_add, 3'd6, 3'd4, 3'd5), rand_pc());
		issue(1'b1, enc_alu_reg(op_add, 3'd4, 3'd6, 3'd4), rand_pc());
	endtask

	task automatic control_test();
		logic [15:0] r;
		for (int i = 0; i < n_ctl; i++) begin
			r = rand16();
			issue(1'b1, enc_lea(r[2:0], r[11:3]), rand_pc());
			r = rand16();
			issue(1'b1, enc_jsr(r[10:0]), rand_pc());
			r = rand16();
			issue(1'b1, enc_jsrr(r[2:0]), rand_pc());
			issue(1'b1, enc_jmp(r[5:3]), rand_pc());
		end
	endtask

	task automatic branch_test();
		logic [15:0] r;
		for (int s = 0; s < 3; s++) begin
			if (s == 0)
				issue(1'b1, enc_alu_imm(op_and, 3'd2, 3'd2, 5'd0), rand_pc()); // z.
			else if (s == 1)
				issue(1'b1, enc_alu_imm(op_add, 3'd2, 3'd2, 5'h1d), rand_pc()); // n.
			else
				issue(1'b1, enc_alu_imm(op_add, 3'd2, 3'd2, 5'd5), rand_pc()); // p.
			for (int m = 0; m < 8; m++) begin
				r = rand16();
				issue(1'b1, enc_br(3'(m), r[8:0]), rand_pc());
			end
		end
	endtask

	task automatic bubble_test();
		lc3b_opcode ops [8];
		logic [15:0] r;
		ops = '{op_ldb, op_stb, op_ldr, op_str, op_ldi, op_sti, op_trap, op_rti};
		for (int i = 0; i < n_mem; i++) begin
			r = rand16();
			issue(1'b1, {ops[i], r[11:0]}, rand_pc());
			idle(1);
		end
	endtask

	initial begin
		errors = 0;
		lcg_state = 32'd90;
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		instr_pc = '0;
		shadow_cc = 3'b010;
		for (int i = 0; i < 8; i++)
			shadow_reg[i] = 16'h0000;
		for (int i = 0; i < 3; i++) begin
			p_wb[i] = 1'b0;
			p_idx[i] = 3'd0;
			p_data[i] = 16'h0000;
			p_redir[i] = 1'b0;
			p_rpc[i] = 16'h0000;
			p_cc[i] = 3'b010;
			p_pc[i] = 16'h0000;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		reset_test();
		seed_test();
		arith_test();
		shift_test();
		bypass_test();
		control_test();
		branch_test();
		bubble_test();
		idle(3); // let the last instructions retire.

		$display("checks done with %0d error(s)", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+test
src/lc3b_pkg.sv
src/control_rom.sv
src/decode_stage.sv
src/regfile.sv
src/alu.sv
src/exec_stage.sv
src/lc3b_datapath.sv
test/tb_lc3b_datapath.sv
